// File: ntm_forget_checker.sv
// Watches the output strobes of one run at a time; expected words must be set before the run starts
`default_nettype none

module ntm_forget_checker (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  armed,  // A run is in progress
  input  wire logic                  b_out_enable,
  input  wire ntm_forget_pkg::data_t b_out,
  input  wire logic                  w_out_enable,
  input  wire ntm_forget_pkg::data_t w_out,
  input  wire logic                  ready,
  input  wire ntm_forget_pkg::data_t exp_db [ntm_forget_pkg::L_SIZE],
  input  wire ntm_forget_pkg::data_t exp_dw [ntm_forget_pkg::X_SIZE][ntm_forget_pkg::L_SIZE],
  output int                         mismatch_count,
  output int                         fault_count,
  output int                         runs_checked
);
  import ntm_forget_pkg::*;

  localparam int W_WORDS = X_SIZE * L_SIZE;  // dW words per run

  int   b_cnt;      // db words seen this run
  int   w_cnt;      // dW words seen this run
  logic ready_due;  // Last dW word was in the previous cycle
  logic gap;

  //////////////////////////////////////////////////////////////////////
  // Sampled mid-cycle, outputs settled since the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (RST) begin
      b_cnt          = 0;
      w_cnt          = 0;
      ready_due      = 1'b0;
      mismatch_count = 0;
      fault_count    = 0;
      runs_checked   = 0;
    end else begin
      // Stream started but not complete, and no word this cycle
      gap = (b_cnt + w_cnt > 0) && (w_cnt < W_WORDS) && !b_out_enable && !w_out_enable;
      if (gap) begin
        fault_count++;
        $display("Gap in the output stream after %0d db and %0d dW words", b_cnt, w_cnt);
      end
      if ((b_out_enable || w_out_enable || ready) && !armed) begin
        fault_count++;
        $display("Output strobe or ready seen while no run is in progress");
      end
      if (b_out_enable && w_out_enable) begin
        fault_count++;
        $display("b_out_enable and w_out_enable are high in the same cycle");
      end

      if (b_out_enable) begin
        if (w_cnt != 0 || b_cnt >= L_SIZE) begin
          fault_count++;
          $display("db word number %0d arrived out of order", b_cnt);
        end else if (b_out !== exp_db[b_cnt]) begin
          mismatch_count++;
          $display("Mismatch b_out[%0d]: got 0x%04h, expected 0x%04h",
                   b_cnt, b_out, exp_db[b_cnt]);
        end
        b_cnt++;
      end

      if (w_out_enable) begin
        if (b_cnt != L_SIZE || w_cnt >= W_WORDS) begin
          fault_count++;
          $display("dW word number %0d arrived out of order", w_cnt);
        end else if (w_out !== exp_dw[w_cnt / L_SIZE][w_cnt % L_SIZE]) begin
          mismatch_count++;
          $display("Mismatch w_out[x=%0d][l=%0d]: got 0x%04h, expected 0x%04h",
                   w_cnt / L_SIZE, w_cnt % L_SIZE, w_out,
                   exp_dw[w_cnt / L_SIZE][w_cnt % L_SIZE]);
        end
        w_cnt++;
      end

      // Ready closes the run, one cycle after the last dW word
      if (ready) begin
        if (b_cnt != L_SIZE || w_cnt != W_WORDS) begin
          fault_count++;
          $display("Ready came after %0d db and %0d dW words instead of %0d and %0d",
                   b_cnt, w_cnt, L_SIZE, W_WORDS);
        end
        b_cnt = 0;
        w_cnt = 0;
        runs_checked++;
      end else if (ready_due) begin
        fault_count++;
        $display("Ready is missing in the cycle after the last dW word");
        b_cnt = 0;
        w_cnt = 0;
        runs_checked++;  // Lets the stimulus go on
      end
      ready_due = w_out_enable && (w_cnt == W_WORDS);
    end
  end

endmodule

`default_nettype wire

// File: ntm_forget_decode.sv
// Expects L_SIZE gates then X_SIZE inputs per step with start before every run; no gap checking
`default_nettype none

module ntm_forget_decode (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire logic                  gate_enable,
  input  wire ntm_forget_pkg::data_t f_in,
  input  wire ntm_forget_pkg::data_t s_in,
  input  wire ntm_forget_pkg::data_t ds_in,
  input  wire logic                  x_enable,
  input  wire ntm_forget_pkg::data_t x_in,
  input  wire logic                  last_in,
  ntm_step_if.decode                 step
);
  import ntm_forget_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic [L_IDX_W-1:0] l_cnt;       // Next gate element
  logic [X_IDX_W-1:0] x_cnt;       // Next input element
  logic               gates_seen;  // All gates of this step taken
  logic               l_wrap;
  logic               x_wrap;
  data_t              s_mem [L_SIZE];  // s of previous step, per l

  assign l_wrap = (l_cnt == L_IDX_W'(L_SIZE - 1));
  assign x_wrap = (x_cnt == X_IDX_W'(X_SIZE - 1));

  //////////////////////////////////////////////////////////////////////
  // Index tracking and strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      l_cnt           <= '0;
      x_cnt           <= '0;
      gates_seen      <= 1'b0;
      step.clear      <= 1'b0;
      step.gate_valid <= 1'b0;
      step.x_valid    <= 1'b0;
      step.last       <= 1'b0;
    end else begin
      step.clear      <= start;
      step.gate_valid <= gate_enable;
      step.x_valid    <= x_enable;
      step.last       <= last_in & x_enable;  // Only counts with a real x

      if (start) begin  // New run restarts both counters
        l_cnt      <= '0;
        x_cnt      <= '0;
        gates_seen <= 1'b0;
      end else begin
        if (gate_enable) begin
          l_cnt <= l_wrap ? '0 : l_cnt + 1'b1;
          if (l_wrap) gates_seen <= 1'b1;  // Inputs may follow now
        end
        if (x_enable) begin
          x_cnt <= x_wrap ? '0 : x_cnt + 1'b1;
          if (x_wrap) gates_seen <= 1'b0;  // Step complete
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sample payload and s(t-1) storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    step.l_idx  <= l_cnt;
    step.f      <= f_in;
    step.ds     <= ds_in;
    step.s_prev <= s_mem[l_cnt];  // Old value before overwrite
    step.x_idx  <= x_cnt;
    step.x      <= x_in;

    if (start) begin
      for (int i = 0; i < L_SIZE; i++) begin
        s_mem[i] <= '0;  // First step sees s(t-1) = 0
      end
    end else if (gate_enable) begin
      s_mem[l_cnt] <= s_in;
    end
  end

  // Inputs of a step only after its full gate vector
  a_x_after_gates : assert property (
    @(posedge CLK) disable iff (RST) x_enable |-> gates_seen
  );

endmodule

`default_nettype wire

// File: ntm_forget_execute.sv
// Gate and input samples keep stream order; an x uses the df vector of the gates just before it
`default_nettype none

module ntm_forget_execute (
  input wire logic    CLK,
  input wire logic    RST,
  ntm_step_if.execute step,
  ntm_grad_if.execute grad
);
  import ntm_forget_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Stage 1 of the df pipeline
  logic               s1_valid;
  logic [L_IDX_W-1:0] s1_l;
  data_t              s1_p1;  // ds * s_prev
  data_t              s1_p2;  // f * (1 - f)

  data_t df;  // Stage 2 product

  // Matching delay for input samples
  logic               xd_valid;
  logic [X_IDX_W-1:0] xd_idx;
  data_t              xd_data;
  logic               xd_last;

  logic done_q;

  data_t df_vec [L_SIZE];          // df(t;l) of current step
  data_t db_acc [L_SIZE];          // Sum of df over steps
  data_t dw_acc [X_SIZE][L_SIZE];  // Sum of df * x over steps

  assign df = q_mul(s1_p1, s1_p2);

  //////////////////////////////////////////////////////////////////////
  // Valid flags and accumulators
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      xd_valid <= 1'b0;
      xd_last  <= 1'b0;
      done_q   <= 1'b0;
      for (int l = 0; l < L_SIZE; l++) begin
        db_acc[l] <= '0;
      end
      for (int x = 0; x < X_SIZE; x++) begin
        for (int l = 0; l < L_SIZE; l++) begin
          dw_acc[x][l] <= '0;
        end
      end
    end else begin
      s1_valid <= step.gate_valid;
      xd_valid <= step.x_valid;
      xd_last  <= step.last;
      done_q   <= xd_last;  // Last MAC lands this cycle

      if (step.clear) begin  // Start of a new run
        for (int l = 0; l < L_SIZE; l++) begin
          db_acc[l] <= '0;
        end
        for (int x = 0; x < X_SIZE; x++) begin
          for (int l = 0; l < L_SIZE; l++) begin
            dw_acc[x][l] <= '0;
          end
        end
      end else begin
        if (s1_valid) begin
          db_acc[s1_l] <= db_acc[s1_l] + df;  // Wraps at 16 bits
        end
        if (xd_valid) begin
          // L_SIZE MACs side by side into one row of dW
          for (int l = 0; l < L_SIZE; l++) begin
            dw_acc[xd_idx][l] <= dw_acc[xd_idx][l] + q_mul(df_vec[l], xd_data);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (step.gate_valid) begin
      s1_l  <= step.l_idx;
      s1_p1 <= q_mul(step.ds, step.s_prev);
      s1_p2 <= q_mul(step.f, ONE_Q - step.f);
    end
    if (step.x_valid) begin
      xd_idx  <= step.x_idx;
      xd_data <= step.x;
    end

    if (step.clear) begin
      for (int l = 0; l < L_SIZE; l++) begin
        df_vec[l] <= '0;
      end
    end else if (s1_valid) begin
      df_vec[s1_l] <= df;  // Read by the next input MACs
    end
  end

  // Read port for the result sequencer
  assign grad.done    = done_q;
  assign grad.rd_data = grad.rd_is_w ? dw_acc[grad.rd_x][grad.rd_l] : db_acc[grad.rd_l];

  // Gate and input samples never arrive in the same cycle
  a_gate_x_exclusive : assert property (
    @(posedge CLK) disable iff (RST) step.gate_valid |-> !step.x_valid
  );

endmodule

`default_nettype wire

// File: ntm_forget_pkg.sv
// Signed Q8.8 words; sizes are fixed at build time and the sums wrap silently at 16 bits
`default_nettype none

package ntm_forget_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word format
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 16;  // Data word width
  localparam int FRAC_W = 8;   // Fraction bits of Q8.8

  typedef logic signed [DATA_W-1:0] data_t;

  localparam data_t ONE_Q = data_t'(256);  // 1.0 in Q8.8

  //////////////////////////////////////////////////////////////////////
  // Problem sizes
  //////////////////////////////////////////////////////////////////////

  localparam int L_SIZE  = 4;  // Gate elements per step
  localparam int X_SIZE  = 4;  // Input elements per step
  localparam int L_IDX_W = 2;  // Index width for l
  localparam int X_IDX_W = 2;  // Index width for x

  //////////////////////////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////////////////////////

  // Q8.8 product
  // Full 32 bit result, arithmetic shift by FRAC_W, low word kept
  function automatic data_t q_mul(input data_t a, input data_t b);
    logic signed [2*DATA_W-1:0] prod;
    prod = a * b;                      // Operands sign extended to 32 bits
    return data_t'(prod >>> FRAC_W);  // Drop fraction, truncate to word
  endfunction

endpackage

`default_nettype wire

// File: ntm_forget_result.sv
// Read-out runs L_SIZE + X_SIZE*L_SIZE cycles without stalls; a new done must wait for ready
`default_nettype none

module ntm_forget_result (
  input  wire logic              CLK,
  input  wire logic              RST,
  ntm_grad_if.result             grad,
  output logic                   b_out_enable,
  output ntm_forget_pkg::data_t  b_out,
  output logic                   w_out_enable,
  output ntm_forget_pkg::data_t  w_out,
  output logic                   ready
);
  import ntm_forget_pkg::*;

  typedef enum logic [1:0] {ph_idle, ph_b, ph_w, ph_fin} phase_t;

  phase_t             phase;
  logic [L_IDX_W-1:0] l_cnt;
  logic [X_IDX_W-1:0] x_cnt;  // Outer loop of dW
  logic               l_last;
  logic               x_last;

  assign l_last = (l_cnt == L_IDX_W'(L_SIZE - 1));
  assign x_last = (x_cnt == X_IDX_W'(X_SIZE - 1));

  // Read address straight from the counters
  assign grad.rd_is_w = (phase == ph_w);
  assign grad.rd_l    = l_cnt;
  assign grad.rd_x    = x_cnt;

  //////////////////////////////////////////////////////////////////////
  // Read-out sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase        <= ph_idle;
      l_cnt        <= '0;
      x_cnt        <= '0;
      b_out_enable <= 1'b0;
      w_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      b_out_enable <= (phase == ph_b);
      w_out_enable <= (phase == ph_w);
      ready        <= (phase == ph_fin);  // After last dW word
      case (phase)
        ph_idle: begin
          l_cnt <= '0;
          x_cnt <= '0;
          if (grad.done) phase <= ph_b;
        end
        ph_b: begin
          l_cnt <= l_last ? '0 : l_cnt + 1'b1;
          if (l_last) phase <= ph_w;  // dW follows with no gap
        end
        ph_w: begin
          l_cnt <= l_last ? '0 : l_cnt + 1'b1;  // Inner loop over l
          if (l_last) begin
            x_cnt <= x_last ? '0 : x_cnt + 1'b1;
            if (x_last) phase <= ph_fin;
          end
        end
        default: phase <= ph_idle;  // ph_fin
      endcase
    end
  end

  // Output words
  always_ff @(posedge CLK) begin
    if (phase == ph_b) b_out <= grad.rd_data;
    if (phase == ph_w) w_out <= grad.rd_data;
  end

  // Execute only finishes a run when no read-out is pending
  a_done_when_idle : assert property (
    @(posedge CLK) disable iff (RST) grad.done |-> (phase == ph_idle)
  );

endmodule

`default_nettype wire

// File: ntm_forget_tb.sv
// Runs a fixed table of streams through the unit; random entries depend on the fixed seed only
`default_nettype none

module ntm_forget_tb;
  import ntm_forget_pkg::*;

  localparam int N_RUNS  = 4;
  localparam int MAX_T   = 3;  // Steps per run at most
  localparam int MAX_GAP = 2;  // Idle cycles before a gate sample at most
  localparam int PERIOD  = 4;

  logic  CLK, RST, start, gate_enable, x_enable, last_in;
  data_t f_in, s_in, ds_in, x_in;
  logic  b_out_enable, w_out_enable, ready;
  data_t b_out, w_out;

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and expected sums
  //////////////////////////////////////////////////////////////////////

  int    run_steps [N_RUNS];
  bit    run_gaps  [N_RUNS];  // Random idle cycles between gate samples
  data_t tab_f     [N_RUNS][MAX_T][L_SIZE];
  data_t tab_s     [N_RUNS][MAX_T][L_SIZE];
  data_t tab_ds    [N_RUNS][MAX_T][L_SIZE];
  data_t tab_x     [N_RUNS][MAX_T][X_SIZE];
  data_t exp_db    [L_SIZE];
  data_t exp_dw    [X_SIZE][L_SIZE];

  logic armed;
  int   mismatch_count, fault_count, runs_checked;
  int   watch_limit;
  logic limit_set;

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  ntm_forget_top i_dut (
    .CLK (CLK), .RST (RST), .start (start),
    .gate_enable (gate_enable), .f_in (f_in), .s_in (s_in), .ds_in (ds_in),
    .x_enable (x_enable), .x_in (x_in), .last_in (last_in),
    .b_out_enable (b_out_enable), .b_out (b_out),
    .w_out_enable (w_out_enable), .w_out (w_out), .ready (ready)
  );

  ntm_forget_checker i_checker (
    .CLK (CLK), .RST (RST), .armed (armed),
    .b_out_enable (b_out_enable), .b_out (b_out),
    .w_out_enable (w_out_enable), .w_out (w_out), .ready (ready),
    .exp_db (exp_db), .exp_dw (exp_dw),
    .mismatch_count (mismatch_count), .fault_count (fault_count),
    .runs_checked (runs_checked)
  );

  // Q8.8 product, bits 23..8 of the 32 bit two's complement product
  function automatic data_t fixed_mult(input data_t a, input data_t b);
    logic [31:0] full;
    full = {{16{a[15]}}, a} * {{16{b[15]}}, b};  // Low 32 bits same for signed
    return data_t'(full[23:8]);
  endfunction

  task automatic fill_table();
    for (int r = 0; r < N_RUNS; r++) begin
      run_steps[r] = (r == 0) ? 1 : (r == 1) ? 3 : 2 + int'($urandom_range(1, 0));
      run_gaps[r]  = (r >= 2);
      for (int t = 0; t < MAX_T; t++) begin
        for (int l = 0; l < L_SIZE; l++) begin
          if (r == 0) begin  // Single step, s(t-1) zero
            tab_f[r][t][l]  = data_t'(64 * (l + 1));
            tab_s[r][t][l]  = data_t'(256 - 48 * l);
            tab_ds[r][t][l] = data_t'(128 + 32 * l);
          end else if (r == 1) begin  // Hand-picked, some negatives
            tab_f[r][t][l]  = data_t'(32 + 48 * l + 16 * t);
            tab_s[r][t][l]  = data_t'(300 - 80 * l - 50 * t);
            tab_ds[r][t][l] = data_t'(256 - 96 * t + 20 * l);
          end else begin
            tab_f[r][t][l]  = data_t'($urandom_range(256, 0));  // f in [0, 1]
            tab_s[r][t][l]  = data_t'(int'($urandom_range(1023, 0)) - 512);
            tab_ds[r][t][l] = data_t'(int'($urandom_range(1023, 0)) - 512);
          end
        end
        for (int x = 0; x < X_SIZE; x++) begin
          if (r < 2) tab_x[r][t][x] = data_t'(64 * (x + 1) - 100 * t - 200 * (1 - r));
          else       tab_x[r][t][x] = data_t'(int'($urandom_range(1023, 0)) - 512);
        end
      end
    end
  endtask

  // Reference model of the forget gate gradient
  task automatic compute_expected(input int r);
    data_t s_prev [L_SIZE];
    data_t df     [L_SIZE];
    data_t p1, p2;
    for (int l = 0; l < L_SIZE; l++) begin
      s_prev[l] = '0;
      exp_db[l] = '0;
      for (int x = 0; x < X_SIZE; x++) exp_dw[x][l] = '0;
    end
    for (int t = 0; t < run_steps[r]; t++) begin
      for (int l = 0; l < L_SIZE; l++) begin
        p1        = fixed_mult(tab_ds[r][t][l], s_prev[l]);
        p2        = fixed_mult(tab_f[r][t][l], data_t'(ONE_Q - tab_f[r][t][l]));
        df[l]     = fixed_mult(p1, p2);
        exp_db[l] = exp_db[l] + df[l];  // Wraps at 16 bits
        s_prev[l] = tab_s[r][t][l];
      end
      for (int x = 0; x < X_SIZE; x++) begin
        for (int l = 0; l < L_SIZE; l++) begin
          exp_dw[x][l] = exp_dw[x][l] + fixed_mult(df[l], tab_x[r][t][x]);
        end
      end
    end
  endtask

  task automatic apply_run(input int r);
    int gap;
    @(negedge CLK) start = 1'b1;
    @(negedge CLK) start = 1'b0;
    for (int t = 0; t < run_steps[r]; t++) begin
      for (int l = 0; l < L_SIZE; l++) begin
        if (run_gaps[r]) begin
          gap = int'($urandom_range(MAX_GAP, 0));
          repeat (gap) @(negedge CLK);
        end
        gate_enable = 1'b1;
        f_in        = tab_f[r][t][l];
        s_in        = tab_s[r][t][l];
        ds_in       = tab_ds[r][t][l];
        @(negedge CLK) gate_enable = 1'b0;
      end
      for (int x = 0; x < X_SIZE; x++) begin
        x_enable = 1'b1;
        x_in     = tab_x[r][t][x];
        last_in  = (t == run_steps[r] - 1) && (x == X_SIZE - 1);  // End of stream
        @(negedge CLK);
        x_enable = 1'b0;
        last_in  = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int seed_word;
    int cycles;
    seed_word   = $urandom(32'ha6d529fd);  // Seeds the generator once
    RST         = 1'b1;
    start       = 1'b0;
    gate_enable = 1'b0;
    x_enable    = 1'b0;
    last_in     = 1'b0;
    f_in        = '0;
    s_in        = '0;
    ds_in       = '0;
    x_in        = '0;
    armed       = 1'b0;
    limit_set   = 1'b0;
    fill_table();
    cycles = 20;
    for (int r = 0; r < N_RUNS; r++) begin  // Worst case gaps plus read-out
      cycles += 18 + run_steps[r] * (L_SIZE * (1 + MAX_GAP) + X_SIZE) + L_SIZE * (1 + X_SIZE);
    end
    watch_limit = cycles * PERIOD + 400;
    limit_set   = 1'b1;
    repeat (3) @(posedge CLK);
    @(negedge CLK) RST = 1'b0;
    repeat (6) @(negedge CLK);  // Idle, checker flags any strobe
    for (int r = 0; r < N_RUNS; r++) begin
      @(posedge CLK);
      compute_expected(r);
      armed = 1'b1;
      apply_run(r);
      wait (runs_checked > r);
      @(posedge CLK);
      armed = 1'b0;
    end
    repeat (4) @(negedge CLK);
    $display("Closing: %0d runs checked, %0d mismatches, %0d other errors",
             runs_checked, mismatch_count, fault_count);
    if (mismatch_count + fault_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_set);
    #(watch_limit);
    $display("Timeout: the runs did not finish within %0d time units", watch_limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ntm_forget_top.sv
// Forget gate gradient unit; driver obeys the strobe order, outputs are strobes with no back-pressure
`default_nettype none

module ntm_forget_top (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire logic                  gate_enable,
  input  wire ntm_forget_pkg::data_t f_in,
  input  wire ntm_forget_pkg::data_t s_in,
  input  wire ntm_forget_pkg::data_t ds_in,
  input  wire logic                  x_enable,
  input  wire ntm_forget_pkg::data_t x_in,
  input  wire logic                  last_in,
  output logic                       b_out_enable,
  output ntm_forget_pkg::data_t      b_out,
  output logic                       w_out_enable,
  output ntm_forget_pkg::data_t      w_out,
  output logic                       ready
);

  ntm_step_if step_bus ();  // Decode to execute
  ntm_grad_if grad_bus ();  // Accumulator read-out

  ntm_forget_decode i_decode (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .gate_enable (gate_enable),
    .f_in        (f_in),
    .s_in        (s_in),
    .ds_in       (ds_in),
    .x_enable    (x_enable),
    .x_in        (x_in),
    .last_in     (last_in),
    .step        (step_bus.decode)
  );

  ntm_forget_execute i_execute (
    .CLK  (CLK),
    .RST  (RST),
    .step (step_bus.execute),
    .grad (grad_bus.execute)
  );

  ntm_forget_result i_result (
    .CLK          (CLK),
    .RST          (RST),
    .grad         (grad_bus.result),
    .b_out_enable (b_out_enable),
    .b_out        (b_out),
    .w_out_enable (w_out_enable),
    .w_out        (w_out),
    .ready        (ready)
  );

endmodule

`default_nettype wire

// File: ntm_grad_if.sv
// Read port into the gradient accumulators; rd_data follows the address in the same cycle
`default_nettype none

interface ntm_grad_if;
  import ntm_forget_pkg::*;

  logic done;  // Accumulators final, one cycle pulse

  // Read address
  logic               rd_is_w;  // 0 selects db, 1 selects dW
  logic [L_IDX_W-1:0] rd_l;
  logic [X_IDX_W-1:0] rd_x;     // Ignored for db

  data_t rd_data;  // Combinational read

  modport execute (
    output done, rd_data,
    input  rd_is_w, rd_l, rd_x
  );

  modport result (
    input  done, rd_data,
    output rd_is_w, rd_l, rd_x
  );

endinterface

`default_nettype wire

// File: ntm_step_if.sv
// Decoded samples move one per cycle with no back-pressure; decode is the only driver
`default_nettype none

interface ntm_step_if;
  import ntm_forget_pkg::*;

  // Run control
  logic clear;  // One cycle after start

  // Gate sample
  logic               gate_valid;
  logic [L_IDX_W-1:0] l_idx;
  data_t              f;       // f(t;l)
  data_t              s_prev;  // s(t-1;l), zero in first step
  data_t              ds;      // Incoming gradient ds(t;l)

  // Input sample
  logic               x_valid;
  logic [X_IDX_W-1:0] x_idx;
  data_t              x;       // x(t;x)

  logic last;  // With the final x of the stream

  modport decode (
    output clear, gate_valid, l_idx, f, s_prev, ds,
    output x_valid, x_idx, x, last
  );

  modport execute (
    input clear, gate_valid, l_idx, f, s_prev, ds,
    input x_valid, x_idx, x, last
  );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the forget gate testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f sources.f --top-module ntm_forget_tb -o ntm_forget_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ntm_forget_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
exit 1

// File: sources.f
ntm_forget_pkg.sv
ntm_step_if.sv
ntm_grad_if.sv
ntm_forget_decode.sv
ntm_forget_execute.sv
ntm_forget_result.sv
ntm_forget_top.sv
ntm_forget_checker.sv
ntm_forget_tb.sv
